// File: common/pmu_reg_pkg.sv
// ------------------------------
// PMU register package
// APB register map, field layouts,
// the write-word views and the APB request
// ------------------------------
package pmu_reg_pkg;

  localparam int PMU_ADDR_W = 12;
  localparam int PMU_DATA_W = 32;

  // Register offsets
  localparam logic [PMU_ADDR_W-1:0] PMU_ADDR_CTRL  = 12'h000;
  localparam logic [PMU_ADDR_W-1:0] PMU_ADDR_LOAD  = 12'h004;
  localparam logic [PMU_ADDR_W-1:0] PMU_ADDR_LPSEL = 12'h008;
  localparam logic [PMU_ADDR_W-1:0] PMU_ADDR_GATE  = 12'h00c;

  // APB request from the bus master
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [PMU_ADDR_W-1:0] paddr;
    logic [PMU_DATA_W-1:0] pwdata;
  } pmu_apb_req_t;

  // ------------------------------
  // Register fields
  // ------------------------------
  // Wakeup source control, bit 0 is wic_en
  typedef struct packed {
    logic timer_en;
    logic debug_en;
    logic event_en;
    logic wic_en;
  } pmu_wake_ctl_t;

  // Low-power mode select, one-hot, bit 0 is normal
  typedef struct packed {
    logic pwr_off;
    logic ret_pwr_off;
    logic clk_off;
    logic clk_slow;
    logic normal;
  } pmu_lp_sel_t;

  // Forced clock-gate bits
  typedef struct packed {
    logic gate1;
    logic gate0;
  } pmu_gate_set_t;

  // One APB data word, seen raw or as one of the register layouts
  typedef union packed {
    logic [PMU_DATA_W-1:0] raw;
    struct packed {
      logic [PMU_DATA_W-5:0] pad;
      pmu_wake_ctl_t         f;
    } ctrl;
    struct packed {
      logic [PMU_DATA_W-6:0] pad;
      pmu_lp_sel_t           f;
    } lp;
    struct packed {
      logic [PMU_DATA_W-3:0] pad;
      pmu_gate_set_t         f;
    } gate;
  } pmu_reg_word_u;

endpackage

// File: common/pmu_ctrl_pkg.sv
// ------------------------------
// PMU control package
// Sleep states, sequencer milestones,
// power-control and clock-gate outputs
// ------------------------------
package pmu_ctrl_pkg;

  // Sleep controller states
  typedef enum logic [2:0] {
    NORMAL         = 3'd0,
    LIGHT_SLP      = 3'd1,
    LSLP_TO_NORMAL = 3'd2,
    DEEP_SLP       = 3'd3,
    DSLP_TO_NORMAL = 3'd4
  } pmu_state_e;

  // ------------------------------
  // Deep-sleep sequencer
  // ------------------------------
  localparam int PMU_SEQ_W = 16;

  // Milestones, counted from the cycle after the start pulse
  localparam logic [PMU_SEQ_W-1:0] PMU_SEQ_STEP_A = 16'h0020;
  localparam logic [PMU_SEQ_W-1:0] PMU_SEQ_STEP_B = 16'h0040;
  localparam logic [PMU_SEQ_W-1:0] PMU_SEQ_STEP_C = 16'h0041;
  // Last step, also where done is raised
  localparam logic [PMU_SEQ_W-1:0] PMU_SEQ_STEP_D = 16'h0060;

  // Power domain controls
  typedef struct packed {
    logic pwr_on;
    logic iso_in;
    logic iso_out;
    logic save;
    logic restore;
  } pmu_pwr_ctl_t;

  // Clock-gate enables to the clock generator
  typedef struct packed {
    logic gate_en1;
    logic gate_en0;
  } pmu_gate_t;

endpackage

// File: design/pmu_apb_regs.sv
// ------------------------------
// PMU APB register file
// Four registers with a combinational read mux
// ------------------------------
`timescale 1ns/1ps

module pmu_apb_regs (
  input  logic                               pmu_clk,
  input  logic                               pad_cpu_rst_b,
  input  pmu_reg_pkg::pmu_apb_req_t          i_apb,
  input  logic                               i_lp_wr_en,
  input  logic [pmu_reg_pkg::PMU_DATA_W-1:0] i_count,
  output logic [pmu_reg_pkg::PMU_DATA_W-1:0] o_prdata,
  output pmu_reg_pkg::pmu_wake_ctl_t         o_wake_ctl,
  output logic [pmu_reg_pkg::PMU_DATA_W-1:0] o_load,
  output pmu_reg_pkg::pmu_lp_sel_t           o_lp_sel,
  output pmu_reg_pkg::pmu_gate_set_t         o_gate_set
);

  import pmu_reg_pkg::*;

  pmu_reg_word_u         wdata;
  pmu_reg_word_u         rdata;
  logic                  wr_en;
  logic                  rd_en;
  pmu_wake_ctl_t         ctrl_q;
  logic [PMU_DATA_W-1:0] load_q;
  pmu_reg_word_u         lp_q;
  pmu_reg_word_u         gate_q;

  assign wdata = i_apb.pwdata;
  assign wr_en = i_apb.psel && i_apb.pwrite && i_apb.penable;
  assign rd_en = i_apb.psel && !i_apb.pwrite;

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      ctrl_q <= '0;
      load_q <= '0;
      lp_q   <= '0;
      gate_q <= '0;
    end
    else if (wr_en)
    begin
      case (i_apb.paddr)
        PMU_ADDR_CTRL:  ctrl_q <= wdata.ctrl.f;
        PMU_ADDR_LOAD:  load_q <= wdata.raw;
        // Mode select is frozen outside normal state
        PMU_ADDR_LPSEL: if (i_lp_wr_en) lp_q.lp <= wdata.lp;
        PMU_ADDR_GATE:  gate_q.gate <= wdata.gate;
        default:        ;
      endcase
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb
  begin
    rdata = '0;
    if (rd_en)
    begin
      case (i_apb.paddr)
        PMU_ADDR_CTRL:  rdata.ctrl.f = ctrl_q;
        // Live count rather than the reload value
        PMU_ADDR_LOAD:  rdata.raw = i_count;
        PMU_ADDR_LPSEL: rdata = lp_q;
        PMU_ADDR_GATE:  rdata = gate_q;
        default:        rdata = '0;
      endcase
    end
  end

  assign o_prdata   = rdata.raw;
  assign o_wake_ctl = ctrl_q;
  assign o_load     = load_q;
  assign o_lp_sel   = lp_q.lp.f;
  assign o_gate_set = gate_q.gate.f;

endmodule

// File: design/pmu_event_timer.sv
// ------------------------------
// PMU event timer
// Reloading down-counter with a zero-count event
// ------------------------------
`timescale 1ns/1ps

module pmu_event_timer (
  input  logic                               pmu_clk,
  input  logic                               pad_cpu_rst_b,
  input  logic                               i_timer_en,
  input  logic [pmu_reg_pkg::PMU_DATA_W-1:0] i_load,
  output logic [pmu_reg_pkg::PMU_DATA_W-1:0] o_count,
  output logic                               o_event
);

  logic                                timer_en_q;
  logic                                reload;
  logic [pmu_reg_pkg::PMU_DATA_W-1:0]  count_q;

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      timer_en_q <= 1'b0;
    else
      timer_en_q <= i_timer_en;
  end

  // Reload when the timer is switched on or runs out
  assign reload = (i_timer_en && !timer_en_q) || (count_q == '0);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      count_q <= '0;
    else if (reload)
      count_q <= i_load;
    else if (i_timer_en)
      count_q <= count_q - 1'b1;
  end

  assign o_count = count_q;
  assign o_event = i_timer_en && (count_q == '0);

endmodule

// File: design/pmu_wakeup.sv
// ------------------------------
// PMU wakeup logic
// lpmd synchronizer, wakeup sources,
// pending flags and the debug request
// ------------------------------
`timescale 1ns/1ps

module pmu_wakeup (
  input  logic                       pmu_clk,
  input  logic                       pad_cpu_rst_b,
  input  logic [1:0]                 i_lpmd_b,
  input  logic                       i_intraw_vld,
  input  logic                       i_had_wakeup_req_b,
  input  logic                       i_event,
  input  pmu_reg_pkg::pmu_wake_ctl_t i_wake_ctl,
  output logic                       o_lpmd_sleep,
  output logic                       o_lpmd_normal,
  output logic                       o_wakeup,
  output logic                       o_jdb_req_b
);

  logic [1:0] lpmd_meta;
  logic [1:0] lpmd_sync;
  logic       dbg_meta_b;
  logic       dbg_sync_b;
  logic       event_q;
  logic       event_pending;
  logic       debug_pending;

  // ------------------------------
  // Input synchronizers
  // ------------------------------
  // Both reset to the idle level
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      lpmd_meta  <= 2'b11;
      lpmd_sync  <= 2'b11;
      dbg_meta_b <= 1'b1;
      dbg_sync_b <= 1'b1;
    end
    else
    begin
      lpmd_meta  <= i_lpmd_b;
      lpmd_sync  <= lpmd_meta;
      dbg_meta_b <= i_had_wakeup_req_b;
      dbg_sync_b <= dbg_meta_b;
    end
  end

  assign o_lpmd_normal = (lpmd_sync == 2'b11);
  assign o_lpmd_sleep  = !o_lpmd_normal;

  // ------------------------------
  // Pending flags
  // ------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      event_q       <= 1'b0;
      event_pending <= 1'b0;
      debug_pending <= 1'b0;
    end
    else
    begin
      event_q <= i_event;
      // Rising timer event while the core asks for sleep
      if (i_event && !event_q && o_lpmd_sleep)
        event_pending <= 1'b1;
      else if (o_lpmd_normal)
        event_pending <= 1'b0;
      if (!dbg_sync_b && o_lpmd_sleep)
        debug_pending <= 1'b1;
      else if (o_lpmd_normal)
        debug_pending <= 1'b0;
    end
  end

  assign o_wakeup = (i_intraw_vld && i_wake_ctl.wic_en && o_lpmd_sleep)
                 || (event_pending && i_wake_ctl.event_en)
                 || (debug_pending && i_wake_ctl.debug_en);

  // Tells the debugger its wakeup request was taken
  assign o_jdb_req_b = !debug_pending;

endmodule

// File: design/pmu_ctrl.sv
// ------------------------------
// PMU sleep controller
// Five-state FSM, sequencer start and
// clock-gate enables
// ------------------------------
`timescale 1ns/1ps

module pmu_ctrl (
  input  logic                       pmu_clk,
  input  logic                       pad_cpu_rst_b,
  input  pmu_reg_pkg::pmu_lp_sel_t   i_lp_sel,
  input  pmu_reg_pkg::pmu_gate_set_t i_gate_set,
  input  logic                       i_lpmd_sleep,
  input  logic                       i_lpmd_normal,
  input  logic                       i_wakeup,
  input  logic                       i_seq_done,
  output logic                       o_lp_wr_en,
  output logic                       o_start_seq,
  output logic                       o_seq_exit,
  output pmu_ctrl_pkg::pmu_gate_t    o_gate
);

  import pmu_ctrl_pkg::*;

  pmu_state_e state_q;
  pmu_state_e state_d;
  logic       light_req;
  logic       deep_req;

  assign light_req = i_lp_sel.clk_slow || i_lp_sel.clk_off;
  assign deep_req  = i_lp_sel.ret_pwr_off || i_lp_sel.pwr_off;

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      state_q <= NORMAL;
    else
      state_q <= state_d;
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      NORMAL:
      begin
        // Normal select keeps the core awake
        if (!i_lp_sel.normal && i_lpmd_sleep)
        begin
          if (light_req)
            state_d = LIGHT_SLP;
          else if (deep_req)
            state_d = DEEP_SLP;
        end
      end
      LIGHT_SLP:
      begin
        if (i_wakeup)
          state_d = LSLP_TO_NORMAL;
      end
      LSLP_TO_NORMAL:
      begin
        if (i_lpmd_normal)
          state_d = NORMAL;
      end
      DEEP_SLP:
      begin
        // Entry sequence must finish first
        if (i_wakeup && i_seq_done)
          state_d = DSLP_TO_NORMAL;
      end
      DSLP_TO_NORMAL:
      begin
        if (i_lpmd_normal && i_seq_done)
          state_d = NORMAL;
      end
      default:
        state_d = NORMAL;
    endcase
  end

  // Start pulse in the cycle that enters a deep-sleep state,
  // so the old done flag is gone once the new state is seen
  assign o_start_seq = (state_d != state_q)
                    && ((state_d == DEEP_SLP) || (state_d == DSLP_TO_NORMAL));
  assign o_seq_exit  = (state_d == DSLP_TO_NORMAL);

  assign o_lp_wr_en = (state_q == NORMAL);

  // ------------------------------
  // Clock gating
  // ------------------------------
  assign o_gate.gate_en0 = i_gate_set.gate0
                        || ((state_q == LIGHT_SLP) && i_lp_sel.clk_slow);
  assign o_gate.gate_en1 = i_gate_set.gate1
                        || ((state_q == LIGHT_SLP) && i_lp_sel.clk_off)
                        || ((state_q == DEEP_SLP) && i_lp_sel.ret_pwr_off);

endmodule

// File: design/pmu_pwr_seq.sv
// ------------------------------
// PMU power sequencer
// Deep-sleep entry and exit steps for
// power, isolation, save and restore
// ------------------------------
`timescale 1ns/1ps

module pmu_pwr_seq (
  input  logic                       pmu_clk,
  input  logic                       pad_cpu_rst_b,
  input  logic                       i_start_seq,
  input  logic                       i_seq_exit,
  output pmu_ctrl_pkg::pmu_pwr_ctl_t o_pwr,
  output logic                       o_seq_done
);

  import pmu_ctrl_pkg::*;

  logic [PMU_SEQ_W-1:0] cnt_q;
  logic                 run_q;
  logic                 exit_q;
  logic                 done_q;
  pmu_pwr_ctl_t         pwr_q;

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      exit_q <= 1'b0;
      done_q <= 1'b0;
      // Domain powered, no isolation
      pwr_q  <= '{pwr_on: 1'b1, default: 1'b0};
    end
    else if (i_start_seq)
    begin
      cnt_q  <= '0;
      run_q  <= 1'b1;
      exit_q <= i_seq_exit;
      done_q <= 1'b0;
    end
    else if (run_q)
    begin
      cnt_q <= cnt_q + 1'b1;
      if (!exit_q)
      begin
        // ------------------------------
        // Entry: isolate, save, power off
        // ------------------------------
        case (cnt_q)
          PMU_SEQ_STEP_A:
          begin
            pwr_q.iso_in  <= 1'b1;
            pwr_q.iso_out <= 1'b1;
          end
          PMU_SEQ_STEP_B: pwr_q.save <= 1'b1;
          PMU_SEQ_STEP_C: pwr_q.save <= 1'b0;
          PMU_SEQ_STEP_D:
          begin
            pwr_q.pwr_on <= 1'b0;
            done_q       <= 1'b1;
            run_q        <= 1'b0;
          end
          default: ;
        endcase
      end
      else
      begin
        // ------------------------------
        // Exit: power on, restore, release
        // ------------------------------
        case (cnt_q)
          PMU_SEQ_STEP_A:
          begin
            pwr_q.pwr_on  <= 1'b1;
            pwr_q.restore <= 1'b1;
          end
          PMU_SEQ_STEP_B:
          begin
            pwr_q.iso_in  <= 1'b0;
            pwr_q.iso_out <= 1'b0;
          end
          PMU_SEQ_STEP_C: pwr_q.restore <= 1'b0;
          PMU_SEQ_STEP_D:
          begin
            done_q <= 1'b1;
            run_q  <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  assign o_pwr      = pwr_q;
  assign o_seq_done = done_q;

endmodule

// File: design/pmu_top.sv
// ------------------------------
// PMU top level
// APB registers, event timer, wakeup logic,
// sleep controller and power sequencer
// ------------------------------
`timescale 1ns/1ps

module pmu_top (
  input  logic                             pmu_clk,
  input  logic                             pad_cpu_rst_b,
  input  pmu_reg_pkg::pmu_apb_req_t        i_apb,
  output logic [pmu_reg_pkg::PMU_DATA_W-1:0] o_prdata,
  input  logic [1:0]                       i_lpmd_b,
  input  logic                             i_intraw_vld,
  input  logic                             i_had_wakeup_req_b,
  output pmu_ctrl_pkg::pmu_gate_t          o_gate,
  output pmu_ctrl_pkg::pmu_pwr_ctl_t       o_pwr,
  output logic                             o_jdb_req_b
);

  import pmu_reg_pkg::*;

  pmu_wake_ctl_t         wake_ctl;
  pmu_lp_sel_t           lp_sel;
  pmu_gate_set_t         gate_set;
  logic [PMU_DATA_W-1:0] load;
  logic [PMU_DATA_W-1:0] count;
  logic                  timer_event;
  logic                  lp_wr_en;
  logic                  lpmd_sleep;
  logic                  lpmd_normal;
  logic                  wakeup;
  logic                  start_seq;
  logic                  seq_exit;
  logic                  seq_done;

  pmu_apb_regs u_apb_regs (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_apb         (i_apb),
    .i_lp_wr_en    (lp_wr_en),
    .i_count       (count),
    .o_prdata      (o_prdata),
    .o_wake_ctl    (wake_ctl),
    .o_load        (load),
    .o_lp_sel      (lp_sel),
    .o_gate_set    (gate_set)
  );

  pmu_event_timer u_event_timer (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_timer_en    (wake_ctl.timer_en),
    .i_load        (load),
    .o_count       (count),
    .o_event       (timer_event)
  );

  pmu_wakeup u_wakeup (
    .pmu_clk            (pmu_clk),
    .pad_cpu_rst_b      (pad_cpu_rst_b),
    .i_lpmd_b           (i_lpmd_b),
    .i_intraw_vld       (i_intraw_vld),
    .i_had_wakeup_req_b (i_had_wakeup_req_b),
    .i_event            (timer_event),
    .i_wake_ctl         (wake_ctl),
    .o_lpmd_sleep       (lpmd_sleep),
    .o_lpmd_normal      (lpmd_normal),
    .o_wakeup           (wakeup),
    .o_jdb_req_b        (o_jdb_req_b)
  );

  pmu_ctrl u_ctrl (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lp_sel      (lp_sel),
    .i_gate_set    (gate_set),
    .i_lpmd_sleep  (lpmd_sleep),
    .i_lpmd_normal (lpmd_normal),
    .i_wakeup      (wakeup),
    .i_seq_done    (seq_done),
    .o_lp_wr_en    (lp_wr_en),
    .o_start_seq   (start_seq),
    .o_seq_exit    (seq_exit),
    .o_gate        (o_gate)
  );

  pmu_pwr_seq u_pwr_seq (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_start_seq   (start_seq),
    .i_seq_exit    (seq_exit),
    .o_pwr         (o_pwr),
    .o_seq_done    (seq_done)
  );

endmodule

// File: tests/pmu_props.sv
// ------------------------------
// PMU power-control properties
// Ordering rules for save, restore,
// isolation and power on the sequencer
// ------------------------------
`timescale 1ns/1ps

module pmu_props (
  input logic                       pmu_clk,
  input logic                       pad_cpu_rst_b,
  input pmu_ctrl_pkg::pmu_pwr_ctl_t i_pwr
);

  // Save and restore never overlap
  save_restore_excl: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    !(i_pwr.save && i_pwr.restore))
    else $error("save and restore are high together");

  // State is saved only behind full isolation
  save_isolated: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    i_pwr.save |-> (i_pwr.iso_in && i_pwr.iso_out))
    else $error("save is high while isolation is not complete");

  // Power goes down only with isolation in place
  pwr_off_isolated: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    $fell(i_pwr.pwr_on) |-> (i_pwr.iso_in && i_pwr.iso_out))
    else $error("pwr_on fell while isolation was low");

endmodule

bind pmu_pwr_seq pmu_props u_props (
  .pmu_clk       (pmu_clk),
  .pad_cpu_rst_b (pad_cpu_rst_b),
  .i_pwr         (o_pwr)
);

// File: tests/tb_pmu.sv
// ------------------------------
// PMU testbench
// Table-driven APB accesses, input changes
// and output waits against the PMU top level
// ------------------------------
`timescale 1ns/1ps

module tb_pmu;

  import pmu_reg_pkg::*;
  import pmu_ctrl_pkg::*;

  localparam int TIMEOUT_CYC = 300;

  // Row kinds
  localparam logic [2:0] K_WR   = 3'd0;
  localparam logic [2:0] K_RD   = 3'd1;
  localparam logic [2:0] K_RDLE = 3'd2;
  localparam logic [2:0] K_SET  = 3'd3;
  localparam logic [2:0] K_WAIT = 3'd4;

  // Outputs a wait row can watch, selected through the address field
  localparam logic [PMU_ADDR_W-1:0] W_GATE0   = 12'd0;
  localparam logic [PMU_ADDR_W-1:0] W_GATE1   = 12'd1;
  localparam logic [PMU_ADDR_W-1:0] W_PWR_ON  = 12'd2;
  localparam logic [PMU_ADDR_W-1:0] W_ISO_IN  = 12'd3;
  localparam logic [PMU_ADDR_W-1:0] W_ISO_OUT = 12'd4;
  localparam logic [PMU_ADDR_W-1:0] W_SAVE    = 12'd5;
  localparam logic [PMU_ADDR_W-1:0] W_RESTORE = 12'd6;
  localparam logic [PMU_ADDR_W-1:0] W_JDB     = 12'd7;
  localparam logic [PMU_ADDR_W-1:0] W_DONE    = 12'd8;
  localparam logic [PMU_ADDR_W-1:0] W_LP_WR   = 12'd9;

  // One stimulus row, lpmd is only used by set rows
  typedef struct packed {
    logic [2:0]            test;
    logic [2:0]            kind;
    logic [PMU_ADDR_W-1:0] addr;
    logic [PMU_DATA_W-1:0] data;
    logic [1:0]            lpmd;
    logic [PMU_DATA_W-1:0] expected;
  } row_t;

  logic                  pmu_clk;
  logic                  pad_cpu_rst_b;
  pmu_apb_req_t          apb;
  logic [PMU_DATA_W-1:0] prdata;
  logic [1:0]            lpmd_b;
  logic                  intraw_vld;
  logic                  had_wakeup_req_b;
  pmu_gate_t             gate;
  pmu_pwr_ctl_t          pwr;
  logic                  jdb_req_b;
  logic                  seq_done_mon;
  logic                  lp_wr_en_mon;

  row_t        rows[$];
  logic [31:0] lcg_state;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_start_errs;
  int          row_idx;

  pmu_top pmu_top_i (
    .pmu_clk            (pmu_clk),
    .pad_cpu_rst_b      (pad_cpu_rst_b),
    .i_apb              (apb),
    .o_prdata           (prdata),
    .i_lpmd_b           (lpmd_b),
    .i_intraw_vld       (intraw_vld),
    .i_had_wakeup_req_b (had_wakeup_req_b),
    .o_gate             (gate),
    .o_pwr              (pwr),
    .o_jdb_req_b        (jdb_req_b)
  );

  // Internal done and normal-state flags, not on the top ports
  assign seq_done_mon = pmu_top_i.u_pwr_seq.o_seq_done;
  assign lp_wr_en_mon = pmu_top_i.u_ctrl.o_lp_wr_en;

  initial
  begin
    pmu_clk = 1'b0;
    forever #5 pmu_clk = ~pmu_clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "register readback";
      2:       return "forced gating";
      3:       return "light sleep clk_slow, interrupt wakeup";
      4:       return "light sleep clk_off, timer wakeup";
      5:       return "debug wakeup request";
      6:       return "deep sleep entry and exit";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic watched(input logic [PMU_ADDR_W-1:0] sel);
    case (sel)
      W_GATE0:   return gate.gate_en0;
      W_GATE1:   return gate.gate_en1;
      W_PWR_ON:  return pwr.pwr_on;
      W_ISO_IN:  return pwr.iso_in;
      W_ISO_OUT: return pwr.iso_out;
      W_SAVE:    return pwr.save;
      W_RESTORE: return pwr.restore;
      W_JDB:     return jdb_req_b;
      W_DONE:    return seq_done_mon;
      W_LP_WR:   return lp_wr_en_mon;
      default:   return 1'bx;
    endcase
  endfunction

  function automatic string watched_name(input logic [PMU_ADDR_W-1:0] sel);
    case (sel)
      W_GATE0:   return "gate_en0";
      W_GATE1:   return "gate_en1";
      W_PWR_ON:  return "pwr_on";
      W_ISO_IN:  return "iso_in";
      W_ISO_OUT: return "iso_out";
      W_SAVE:    return "save";
      W_RESTORE: return "restore";
      W_JDB:     return "o_jdb_req_b";
      W_DONE:    return "seq_done";
      W_LP_WR:   return "lp_wr_en";
      default:   return "unknown";
    endcase
  endfunction

  task automatic add_row(input int t, input logic [2:0] k, input logic [PMU_ADDR_W-1:0] a,
                         input logic [PMU_DATA_W-1:0] d, input logic [1:0] l,
                         input logic [PMU_DATA_W-1:0] e);
    row_t r;
    r.test     = t[2:0];
    r.kind     = k;
    r.addr     = a;
    r.data     = d;
    r.lpmd     = l;
    r.expected = e;
    rows.push_back(r);
  endtask

  // ------------------------------
  // APB access and waits
  // ------------------------------
  task automatic apb_write(input logic [PMU_ADDR_W-1:0] addr, input logic [PMU_DATA_W-1:0] data);
    apb.psel    = 1'b1;
    apb.pwrite  = 1'b1;
    apb.penable = 1'b0;
    apb.paddr   = addr;
    apb.pwdata  = data;
    @(negedge pmu_clk);
    apb.penable = 1'b1;
    @(negedge pmu_clk);
    apb = '0;
  endtask

  task automatic apb_read(input logic [PMU_ADDR_W-1:0] addr, output logic [PMU_DATA_W-1:0] data);
    apb.psel    = 1'b1;
    apb.pwrite  = 1'b0;
    apb.penable = 1'b0;
    apb.paddr   = addr;
    @(negedge pmu_clk);
    apb.penable = 1'b1;
    @(negedge pmu_clk);
    // Sampled away from the rising edge
    data = prdata;
    apb  = '0;
  endtask

  task automatic wait_value(input logic [PMU_ADDR_W-1:0] sel, input logic val, output logic ok);
    int n;
    n = 0;
    while (watched(sel) !== val && n < TIMEOUT_CYC)
    begin
      @(negedge pmu_clk);
      n++;
    end
    ok = (watched(sel) === val);
  endtask

  task automatic run_row(input row_t r);
    logic [PMU_DATA_W-1:0] got;
    logic                  ok;
    case (r.kind)
      K_WR:
        apb_write(r.addr, r.data);
      K_RD:
      begin
        apb_read(r.addr, got);
        check_cnt++;
        assert (got === r.expected)
        else
        begin
          $display("FAILED prdata[%h]: got %h expected %h", r.addr, got, r.expected);
          err_cnt++;
        end
      end
      K_RDLE:
      begin
        apb_read(r.addr, got);
        check_cnt++;
        assert (got <= r.expected)
        else
        begin
          $display("FAILED prdata[%h]: got %h above limit %h", r.addr, got, r.expected);
          err_cnt++;
        end
      end
      K_SET:
      begin
        lpmd_b           = r.lpmd;
        intraw_vld       = r.data[0];
        had_wakeup_req_b = r.data[1];
      end
      K_WAIT:
      begin
        wait_value(r.addr, r.expected[0], ok);
        check_cnt++;
        assert (ok)
        else
        begin
          $display("Timed out after %0d cycles waiting for %s to become %0d",
                   TIMEOUT_CYC, watched_name(r.addr), r.expected[0]);
          err_cnt++;
        end
      end
      default:
      begin
        $display("Unknown row kind %0d in the stimulus table", r.kind);
        err_cnt++;
      end
    endcase
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic build_table();
    logic [31:0] r;
    int          i;
    // Reset values, then random readback
    add_row(1, K_RD, PMU_ADDR_CTRL, 32'h0, 2'b11, 32'h0);
    add_row(1, K_RD, PMU_ADDR_LOAD, 32'h0, 2'b11, 32'h0);
    add_row(1, K_RD, PMU_ADDR_LPSEL, 32'h0, 2'b11, 32'h0);
    add_row(1, K_RD, PMU_ADDR_GATE, 32'h0, 2'b11, 32'h0);
    for (i = 0; i < 2; i++)
    begin
      r = next_rand();
      add_row(1, K_WR, PMU_ADDR_LPSEL, r, 2'b11, 32'h0);
      add_row(1, K_RD, PMU_ADDR_LPSEL, 32'h0, 2'b11, r);
      r = next_rand();
      add_row(1, K_WR, PMU_ADDR_GATE, r, 2'b11, 32'h0);
      add_row(1, K_RD, PMU_ADDR_GATE, 32'h0, 2'b11, r);
      r = next_rand();
      add_row(1, K_WR, PMU_ADDR_CTRL, r, 2'b11, 32'h0);
      add_row(1, K_RD, PMU_ADDR_CTRL, 32'h0, 2'b11, {28'h0, r[3:0]});
    end
    add_row(1, K_RD, 12'h010, 32'h0, 2'b11, 32'h0);
    add_row(1, K_WR, PMU_ADDR_LPSEL, 32'h0, 2'b11, 32'h0);
    add_row(1, K_WR, PMU_ADDR_GATE, 32'h0, 2'b11, 32'h0);
    add_row(1, K_WR, PMU_ADDR_CTRL, 32'h0, 2'b11, 32'h0);
    // Forced gates follow the written bits
    add_row(2, K_WAIT, W_GATE0, 32'h0, 2'b11, 32'h0);
    add_row(2, K_WR, PMU_ADDR_GATE, 32'h1, 2'b11, 32'h0);
    add_row(2, K_WAIT, W_GATE0, 32'h0, 2'b11, 32'h1);
    add_row(2, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h0);
    add_row(2, K_WR, PMU_ADDR_GATE, 32'h3, 2'b11, 32'h0);
    add_row(2, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h1);
    add_row(2, K_WR, PMU_ADDR_GATE, 32'h0, 2'b11, 32'h0);
    add_row(2, K_WAIT, W_GATE0, 32'h0, 2'b11, 32'h0);
    add_row(2, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h0);
    // Light sleep, clk_slow, interrupt wakeup
    add_row(3, K_WR, PMU_ADDR_LPSEL, 32'h2, 2'b11, 32'h0);
    add_row(3, K_WR, PMU_ADDR_CTRL, 32'h1, 2'b11, 32'h0);
    add_row(3, K_SET, 12'h0, 32'h2, 2'b01, 32'h0);
    add_row(3, K_WAIT, W_GATE0, 32'h0, 2'b11, 32'h1);
    add_row(3, K_WR, PMU_ADDR_LPSEL, 32'h4, 2'b11, 32'h0);
    add_row(3, K_RD, PMU_ADDR_LPSEL, 32'h0, 2'b11, 32'h2);
    add_row(3, K_SET, 12'h0, 32'h3, 2'b01, 32'h0);
    add_row(3, K_WAIT, W_GATE0, 32'h0, 2'b11, 32'h0);
    add_row(3, K_SET, 12'h0, 32'h2, 2'b11, 32'h0);
    add_row(3, K_WAIT, W_LP_WR, 32'h0, 2'b11, 32'h1);
    add_row(3, K_WR, PMU_ADDR_LPSEL, 32'h1, 2'b11, 32'h0);
    add_row(3, K_RD, PMU_ADDR_LPSEL, 32'h0, 2'b11, 32'h1);
    // Light sleep, clk_off, timer event wakeup
    add_row(4, K_WR, PMU_ADDR_LPSEL, 32'h4, 2'b11, 32'h0);
    add_row(4, K_WR, PMU_ADDR_LOAD, 32'h5, 2'b11, 32'h0);
    add_row(4, K_WR, PMU_ADDR_CTRL, 32'h2, 2'b11, 32'h0);
    add_row(4, K_SET, 12'h0, 32'h2, 2'b01, 32'h0);
    add_row(4, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h1);
    add_row(4, K_WR, PMU_ADDR_CTRL, 32'ha, 2'b11, 32'h0);
    add_row(4, K_RDLE, PMU_ADDR_LOAD, 32'h0, 2'b11, 32'h5);
    add_row(4, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h0);
    add_row(4, K_WR, PMU_ADDR_CTRL, 32'h0, 2'b11, 32'h0);
    add_row(4, K_SET, 12'h0, 32'h2, 2'b11, 32'h0);
    add_row(4, K_WAIT, W_LP_WR, 32'h0, 2'b11, 32'h1);
    // Debug wakeup request
    add_row(5, K_WR, PMU_ADDR_LPSEL, 32'h1, 2'b11, 32'h0);
    add_row(5, K_WR, PMU_ADDR_CTRL, 32'h4, 2'b11, 32'h0);
    add_row(5, K_WAIT, W_JDB, 32'h0, 2'b11, 32'h1);
    add_row(5, K_SET, 12'h0, 32'h0, 2'b01, 32'h0);
    add_row(5, K_WAIT, W_JDB, 32'h0, 2'b11, 32'h0);
    add_row(5, K_SET, 12'h0, 32'h2, 2'b11, 32'h0);
    add_row(5, K_WAIT, W_JDB, 32'h0, 2'b11, 32'h1);
    add_row(5, K_WR, PMU_ADDR_CTRL, 32'h0, 2'b11, 32'h0);
    // Deep sleep with ret_pwr_off
    add_row(6, K_WR, PMU_ADDR_LPSEL, 32'h8, 2'b11, 32'h0);
    add_row(6, K_WR, PMU_ADDR_CTRL, 32'h1, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_PWR_ON, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_ISO_IN, 32'h0, 2'b11, 32'h0);
    add_row(6, K_SET, 12'h0, 32'h2, 2'b01, 32'h0);
    add_row(6, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_ISO_IN, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_ISO_OUT, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_SAVE, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_SAVE, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_PWR_ON, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_DONE, 32'h0, 2'b11, 32'h1);
    add_row(6, K_SET, 12'h0, 32'h3, 2'b01, 32'h0);
    add_row(6, K_WAIT, W_DONE, 32'h0, 2'b11, 32'h0);
    add_row(6, K_SET, 12'h0, 32'h2, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_PWR_ON, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_RESTORE, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_ISO_IN, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_ISO_OUT, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_RESTORE, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_LP_WR, 32'h0, 2'b11, 32'h1);
    // Deep sleep with pwr_off keeps gate_en1 low
    add_row(6, K_WR, PMU_ADDR_LPSEL, 32'h10, 2'b11, 32'h0);
    add_row(6, K_SET, 12'h0, 32'h2, 2'b01, 32'h0);
    add_row(6, K_WAIT, W_ISO_IN, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_PWR_ON, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_GATE1, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_DONE, 32'h0, 2'b11, 32'h1);
    add_row(6, K_SET, 12'h0, 32'h3, 2'b01, 32'h0);
    add_row(6, K_WAIT, W_DONE, 32'h0, 2'b11, 32'h0);
    add_row(6, K_SET, 12'h0, 32'h2, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_PWR_ON, 32'h0, 2'b11, 32'h1);
    add_row(6, K_WAIT, W_ISO_IN, 32'h0, 2'b11, 32'h0);
    add_row(6, K_WAIT, W_LP_WR, 32'h0, 2'b11, 32'h1);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    pad_cpu_rst_b    = 1'b0;
    apb              = '0;
    lpmd_b           = 2'b11;
    intraw_vld       = 1'b0;
    had_wakeup_req_b = 1'b1;
    lcg_state        = 32'he42e_97cb;
    err_cnt          = 0;
    check_cnt        = 0;
    test_cnt         = 0;
    test_start_errs  = 0;
    build_table();
    repeat (4) @(negedge pmu_clk);
    pad_cpu_rst_b = 1'b1;
    @(negedge pmu_clk);
    for (row_idx = 0; row_idx < rows.size(); row_idx++)
    begin
      run_row(rows[row_idx]);
      if (row_idx == rows.size() - 1 || rows[row_idx + 1].test != rows[row_idx].test)
      begin
        test_cnt++;
        $display("test %0d %s: %s", rows[row_idx].test, test_name(int'(rows[row_idx].test)),
                 (err_cnt == test_start_errs) ? "pass" : "fail");
        test_start_errs = err_cnt;
      end
    end
    $display("tests %0d, checks %0d, failures %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: project.f
common/pmu_reg_pkg.sv
common/pmu_ctrl_pkg.sv
design/pmu_apb_regs.sv
design/pmu_event_timer.sv
design/pmu_wakeup.sv
design/pmu_ctrl.sv
design/pmu_pwr_seq.sv
design/pmu_top.sv
tests/pmu_props.sv
tests/tb_pmu.sv

// File: run.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tb_pmu \
  -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_pmu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
